//--- Makefile
VERILATOR ?= verilator
TOP       := core_top_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_ARGS  := +verilator+error+limit+100
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
hw/core_cfg_pkg.sv
hw/core_io_pkg.sv
hw/core_settings.sv
hw/analogizer_config.sv
hw/reset_stretch.sv
hw/control_mapper.sv
hw/arcade_inputs.sv
hw/video_output.sv
hw/core_top.sv
tests/core_top_checker.sv
tests/core_top_tb.sv

//--- hw/analogizer_config.sv
//////////////////////////////
// analogizer config register
// SNAC type, player assignment, video type
// and screen blank, readable over the bridge
//////////////////////////////

`timescale 1ns/100ps

module analogizer_config
    import core_cfg_pkg::*;
    import core_io_pkg::*;
(
    input  logic            clk_74a,
    input  logic            reset,
    input  bridge_addr_t    bridge_addr,
    input  logic            bridge_rd,
    input  logic            bridge_wr,
    input  bridge_data_t    bridge_wr_data,
    output bridge_data_t    bridge_rd_data,
    output analogizer_cfg_t cfg
);

    logic cfg_hit;

    assign cfg_hit = (bridge_addr == addr_analogizer_cfg);

    // low 12 bits of the write are the whole word
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            cfg <= '0;
        end else if (bridge_wr && cfg_hit) begin
            cfg <= analogizer_cfg_t'(bridge_wr_data[11:0]);
        end
    end

    // only read source on the bus
    // zero-extended word at its address, zero elsewhere
    always_comb begin
        bridge_rd_data = '0;
        if (bridge_rd && cfg_hit) begin
            bridge_rd_data[11:0] = cfg;
        end
    end

endmodule

//--- hw/arcade_inputs.sv
//////////////////////////////
// arcade input packer
// p1 pad to the 7-bit control word,
// select release becomes a long coin pulse
//////////////////////////////

`timescale 1ns/100ps

module arcade_inputs import core_io_pkg::*; #(
    parameter int COIN_PULSE_CYCLES = 1048575
) (
    input  logic         clk_74a,
    input  logic         reset,
    input  cont_key_t    p1_controls,
    output arcade_ctrl_t arcade_controls
);

    localparam int CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    logic             select_q;
    logic             select_fall;
    logic [CNT_W-1:0] coin_cnt;

    // coin is on select, bit 14
    assign select_fall = select_q && !p1_controls[14];

    // coin counter, loads only when idle
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            select_q <= 1'b0;
            coin_cnt <= '0;
        end else begin
            select_q <= p1_controls[14];
            if (coin_cnt != '0) begin
                coin_cnt <= coin_cnt - 1'b1;
            end else if (select_fall) begin
                coin_cnt <= CNT_W'(COIN_PULSE_CYCLES);
            end
        end
    end

    // output word, coin one stage behind the counter load
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            arcade_controls <= '0;
        end else begin
            arcade_controls.up    <= p1_controls[0];
            arcade_controls.down  <= p1_controls[1];
            arcade_controls.left  <= p1_controls[2];
            arcade_controls.right <= p1_controls[3];
            arcade_controls.fire  <= p1_controls[4];
            arcade_controls.start <= p1_controls[15];
            arcade_controls.coin  <= (coin_cnt != '0);
        end
    end

endmodule

//--- hw/control_mapper.sv
//////////////////////////////
// player control mapper
// picks pocket or SNAC pads per player,
// analog sticks decoded to directions
//////////////////////////////

`timescale 1ns/100ps

module control_mapper import core_io_pkg::*; (
    input  logic            clk_74a,
    input  logic            reset,
    input  cont_key_t       cont1_key,
    input  cont_key_t       cont2_key,
    input  cont_key_t       snac1_key,
    input  cont_key_t       snac2_key,
    input  cont_joy_t       snac1_joy,
    input  cont_joy_t       snac2_joy,
    input  analogizer_cfg_t cfg,
    input  logic            analogizer_ena,
    output cont_key_t       p1_controls,
    output cont_key_t       p2_controls
);

    logic      snac_is_analog;
    logic      snac_off;
    cont_key_t snac1_pad;
    cont_key_t snac2_pad;

    // direction bits from the stick when analog, else buttons 0..3 as is
    function automatic cont_key_t snac_dirs(
        input cont_key_t key,
        input cont_joy_t joy,
        input logic      analog
    );
        axis_t     x;
        axis_t     y;
        cont_key_t pad;
        x   = joy[7:0];
        y   = joy[15:8];
        pad = key;
        if (analog) begin
            pad[0] = (y < stick_low);
            pad[1] = (y > stick_high);
            pad[2] = (x < stick_low);
            pad[3] = (x > stick_high);
        end
        return pad;
    endfunction

    assign snac_is_analog = (cfg.cont_type == snac_analog_a) ||
                            (cfg.cont_type == snac_analog_b);
    assign snac_off       = (cfg.cont_type == snac_none) || !analogizer_ena;

    assign snac1_pad = snac_dirs(snac1_key, snac1_joy, snac_is_analog);
    assign snac2_pad = snac_dirs(snac2_key, snac2_joy, snac_is_analog);

    ////////////////////////////////
    // source select, one register stage
    ////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else if (snac_off) begin
            // plain pocket pads
            p1_controls <= cont1_key;
            p2_controls <= cont2_key;
        end else begin
            case (cfg.assignment)
                p1_to_p1: begin
                    p1_controls <= snac1_pad;
                    p2_controls <= cont1_key;
                end
                p1_to_p2: begin
                    // player two sees raw SNAC1 buttons, no stick decode
                    p1_controls <= cont1_key;
                    p2_controls <= snac1_key;
                end
                both_straight: begin
                    p1_controls <= snac1_pad;
                    p2_controls <= snac2_pad;
                end
                both_swapped: begin
                    p1_controls <= snac2_pad;
                    p2_controls <= snac1_pad;
                end
                default: begin
                    p1_controls <= cont1_key;
                    p2_controls <= cont2_key;
                end
            endcase
        end
    end

endmodule

//--- hw/core_cfg_pkg.sv
//////////////////////////////
// core configuration package
// bridge bus widths, setting register addresses
// and the DIP switch word handed to the game core
//////////////////////////////

package core_cfg_pkg;

    // bridge bus
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // setting registers, exact match only
    localparam bridge_addr_t addr_lives          = 32'h2000_0000;
    localparam bridge_addr_t addr_difficulty     = 32'h3000_0000;
    localparam bridge_addr_t addr_bonus          = 32'h4000_0000;
    localparam bridge_addr_t addr_demo_sounds    = 32'h5000_0000;
    localparam bridge_addr_t addr_reset          = 32'h8000_0000;
    localparam bridge_addr_t addr_analogizer_ena = 32'hF200_0000;
    localparam bridge_addr_t addr_analogizer_cfg = 32'hF700_0000;

    // setting fields
    typedef logic [1:0] lives_t;
    typedef logic [2:0] difficulty_t;
    typedef logic [2:0] bonus_t;

    // dip word with its two bytes already swapped for the core
    // upper half is the original low byte, lower half the original high byte
    typedef struct packed {
        logic [1:0]  zero_lo;
        difficulty_t difficulty;
        bonus_t      bonus;
        logic        demo_sounds;
        logic        zero_mid;
        lives_t      lives;
        logic [3:0]  zero_hi;
    } dip_word_t;

endpackage

//--- hw/core_io_pkg.sv
//////////////////////////////
// core i/o package
// pad, SNAC and video types, plus the
// analog stick thresholds
//////////////////////////////

package core_io_pkg;

    // pocket and SNAC pad words
    // key bits 0..3 up/down/left/right, 4 A, 14 select, 15 start
    typedef logic [15:0] cont_key_t;
    // stick word, 7:0 X and 15:8 Y
    typedef logic [31:0] cont_joy_t;
    // one stick axis
    typedef logic [7:0] axis_t;

    // SNAC controller type, anything not listed is digital
    typedef enum logic [4:0] {
        snac_none     = 5'h00,
        snac_analog_a = 5'h12,
        snac_analog_b = 5'h13
    } snac_type_t;

    // which SNAC pad lands on which player
    typedef enum logic [1:0] {
        p1_to_p1,
        p1_to_p2,
        both_straight,
        both_swapped
    } snac_assign_t;

    // analogizer config word, bits 11:0 of the bridge word
    typedef struct packed {
        logic         blank_screen;
        logic [3:0]   video_type;
        snac_assign_t assignment;
        snac_type_t   cont_type;
    } analogizer_cfg_t;

    // arcade control word, msb first
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } arcade_ctrl_t;

    // colour, 4 or 8 bits per channel, red on top
    typedef logic [11:0] rgb12_t;
    typedef logic [23:0] rgb24_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } video_sync_t;

    // stick deadzone, idle sits near 7f
    localparam axis_t stick_low  = 8'h40;
    localparam axis_t stick_high = 8'hC0;

endpackage

//--- hw/core_settings.sv
//////////////////////////////
// setting registers
// host writes over the bridge, packed
// into the core DIP word
//////////////////////////////

`timescale 1ns/100ps

module core_settings import core_cfg_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output dip_word_t    dips,
    output logic         analogizer_ena,
    output logic         reset_toggle
);

    lives_t      lives;
    difficulty_t difficulty;
    bonus_t      bonus;
    logic        demo_sounds;

    // one register per address, only the low bits are kept
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            lives          <= '0;
            difficulty     <= '0;
            bonus          <= '0;
            demo_sounds    <= 1'b0;
            analogizer_ena <= 1'b0;
            reset_toggle   <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                addr_lives:          lives          <= bridge_wr_data[1:0];
                addr_difficulty:     difficulty     <= bridge_wr_data[2:0];
                addr_bonus:          bonus          <= bridge_wr_data[2:0];
                addr_demo_sounds:    demo_sounds    <= bridge_wr_data[0];
                addr_analogizer_ena: analogizer_ena <= bridge_wr_data[0];
                // any write flips it, data ignored
                addr_reset:          reset_toggle   <= ~reset_toggle;
                default: ;
            endcase
        end
    end

    // byte-swapped layout lives in the struct itself
    always_comb begin
        dips             = '0;
        dips.difficulty  = difficulty;
        dips.bonus       = bonus;
        dips.demo_sounds = demo_sounds;
        dips.lives       = lives;
    end

endmodule

//--- hw/core_top.sv
//////////////////////////////
// core top level
// bridge registers, reset, controls and
// video glue around the game core
//////////////////////////////

`timescale 1ns/100ps

module core_top
    import core_cfg_pkg::*;
    import core_io_pkg::*;
#(
    parameter int RESET_HOLD        = 2097151,
    parameter int COIN_PULSE_CYCLES = 1048575
) (
    input  logic         clk_74a,
    input  logic         reset,
    // bridge, single host master
    input  logic         bridge_reset,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_rd,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output bridge_data_t bridge_rd_data,
    // pads
    input  cont_key_t    cont1_key,
    input  cont_key_t    cont2_key,
    input  cont_key_t    snac1_key,
    input  cont_key_t    snac2_key,
    input  cont_joy_t    snac1_joy,
    input  cont_joy_t    snac2_joy,
    // game core side
    input  rgb12_t       core_rgb,
    input  video_sync_t  core_sync,
    output dip_word_t    dips,
    output logic         core_reset,
    output arcade_ctrl_t arcade_controls,
    // scaler side
    output rgb24_t       video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs
);

    logic            analogizer_ena;
    logic            reset_toggle;
    analogizer_cfg_t cfg;
    cont_key_t       p1_controls;

    ////////////////////////////////
    // bridge registers, address decode only
    ////////////////////////////////
    core_settings u_settings (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .dips           (dips),
        .analogizer_ena (analogizer_ena),
        .reset_toggle   (reset_toggle)
    );

    analogizer_config u_analogizer_cfg (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cfg            (cfg)
    );

    reset_stretch #(
        .RESET_HOLD (RESET_HOLD)
    ) u_reset (
        .clk_74a      (clk_74a),
        .reset        (reset),
        .bridge_reset (bridge_reset),
        .reset_toggle (reset_toggle),
        .core_reset   (core_reset)
    );

    ////////////////////////////////
    // controls
    ////////////////////////////////
    // player two output left open, the core takes one player
    control_mapper u_mapper (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac1_key      (snac1_key),
        .snac2_key      (snac2_key),
        .snac1_joy      (snac1_joy),
        .snac2_joy      (snac2_joy),
        .cfg            (cfg),
        .analogizer_ena (analogizer_ena),
        .p1_controls    (p1_controls),
        .p2_controls    ()
    );

    arcade_inputs #(
        .COIN_PULSE_CYCLES (COIN_PULSE_CYCLES)
    ) u_arcade (
        .clk_74a         (clk_74a),
        .reset           (reset),
        .p1_controls     (p1_controls),
        .arcade_controls (arcade_controls)
    );

    ////////////////////////////////
    // video
    ////////////////////////////////
    video_output u_video (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .core_rgb       (core_rgb),
        .core_sync      (core_sync),
        .cfg            (cfg),
        .analogizer_ena (analogizer_ena),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

endmodule

//--- hw/reset_stretch.sv
//////////////////////////////
// manual reset stretcher
// toggle change starts a long core reset,
// merged with bridge and system reset
//////////////////////////////

`timescale 1ns/100ps

module reset_stretch #(
    parameter int RESET_HOLD = 2097151
) (
    input  logic clk_74a,
    input  logic reset,
    input  logic bridge_reset,
    input  logic reset_toggle,
    output logic core_reset
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    typedef enum logic {
        st_idle,
        st_hold
    } state_t;

    state_t           state;
    logic             toggle_q;
    logic [CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            state    <= st_idle;
            toggle_q <= 1'b0;
            hold_cnt <= '0;
        end else begin
            // tracked every cycle, so a flip mid-stretch is swallowed
            toggle_q <= reset_toggle;
            case (state)
                st_idle: begin
                    if (reset_toggle != toggle_q) begin
                        state    <= st_hold;
                        hold_cnt <= CNT_W'(RESET_HOLD - 1);
                    end
                end
                st_hold: begin
                    // counts down to zero, RESET_HOLD cycles in total
                    if (hold_cnt == '0) begin
                        state <= st_idle;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign core_reset = (state == st_hold) | bridge_reset | reset;

endmodule

//--- hw/video_output.sv
//////////////////////////////
// video output formatter
// blanking, 4 to 8 bit colour and
// sync edge pulses, one cycle latency
//////////////////////////////

`timescale 1ns/100ps

module video_output import core_io_pkg::*; (
    input  logic            clk_74a,
    input  logic            reset,
    input  rgb12_t          core_rgb,
    input  video_sync_t     core_sync,
    input  analogizer_cfg_t cfg,
    input  logic            analogizer_ena,
    output rgb24_t          video_rgb,
    output logic            video_de,
    output logic            video_hs,
    output logic            video_vs
);

    rgb12_t pixel;
    logic   active;
    logic   hs_q;
    logic   vs_q;

    // pocket screen forced black when the analogizer drives the display
    assign pixel  = (cfg.blank_screen && analogizer_ena) ? '0 : core_rgb;
    assign active = !(core_sync.hblank || core_sync.vblank);

    // colour, zero in blanking
    always_ff @(posedge clk_74a) begin
        if (active) begin
            video_rgb <= {{2{pixel[11:8]}}, {2{pixel[7:4]}}, {2{pixel[3:0]}}};
        end else begin
            video_rgb <= '0;
        end
    end

    // data enable and rising-edge sync pulses
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
        end else begin
            video_de <= active;
            video_hs <= core_sync.hs && !hs_q;
            video_vs <= core_sync.vs && !vs_q;
            hs_q     <= core_sync.hs;
            vs_q     <= core_sync.vs;
        end
    end

endmodule

//--- tests/core_top_checker.sv
//////////////////////////////
// core_top assertion checker
// reset combine, idle bridge read data,
// data enable and sync pulse timing
//////////////////////////////

`timescale 1ns/100ps

module core_top_checker
    import core_cfg_pkg::*;
    import core_io_pkg::*;
(
    input logic         clk_74a,
    input logic         reset,
    input logic         bridge_reset,
    input bridge_addr_t bridge_addr,
    input logic         bridge_rd,
    input bridge_data_t bridge_rd_data,
    input logic         core_reset,
    input video_sync_t  core_sync,
    input rgb24_t       video_rgb,
    input logic         video_de,
    input logic         video_hs,
    input logic         video_vs
);

    // failed assertions so far, read back by the testbench
    int fail_count = 0;

    logic blanking;
    logic cfg_read;

    assign blanking = core_sync.hblank || core_sync.vblank;
    assign cfg_read = bridge_rd && (bridge_addr == addr_analogizer_cfg);

    ////////////////////////////////
    // reset and bridge
    ////////////////////////////////
    a_reset_combine: assert property (@(posedge clk_74a)
        (reset || bridge_reset) |-> core_reset
    ) else begin
        fail_count++;
        $error("core_reset low while a reset source is high");
    end

    // only the config address ever drives read data
    a_rd_idle_zero: assert property (@(posedge clk_74a)
        !cfg_read |-> (bridge_rd_data == '0)
    ) else begin
        fail_count++;
        $error("bridge_rd_data nonzero outside a config read");
    end

    ////////////////////////////////
    // video, one cycle behind the core
    ////////////////////////////////
    a_de_active: assert property (@(posedge clk_74a) disable iff (reset)
        !blanking |=> video_de
    ) else begin
        fail_count++;
        $error("video_de low after an active pixel");
    end

    a_de_blank: assert property (@(posedge clk_74a) disable iff (reset)
        blanking |=> (!video_de && video_rgb == '0)
    ) else begin
        fail_count++;
        $error("video_de or colour not cleared after blanking");
    end

    // hs and vs, one pulse per rising edge and nothing else
    a_hs_rise: assert property (@(posedge clk_74a) disable iff (reset)
        $rose(core_sync.hs) |=> video_hs
    ) else begin
        fail_count++;
        $error("no video_hs pulse after hs rose");
    end

    a_hs_quiet: assert property (@(posedge clk_74a) disable iff (reset)
        !$rose(core_sync.hs) |=> !video_hs
    ) else begin
        fail_count++;
        $error("video_hs high without an hs rising edge");
    end

    a_vs_rise: assert property (@(posedge clk_74a) disable iff (reset)
        $rose(core_sync.vs) |=> video_vs
    ) else begin
        fail_count++;
        $error("no video_vs pulse after vs rose");
    end

    a_vs_quiet: assert property (@(posedge clk_74a) disable iff (reset)
        !$rose(core_sync.vs) |=> !video_vs
    ) else begin
        fail_count++;
        $error("video_vs high without a vs rising edge");
    end

endmodule

bind core_top core_top_checker u_checker (.*);

//--- tests/core_top_tb.sv
//////////////////////////////
// core_top testbench
// bridge settings, manual reset, pad mapping,
// coin pulse and video formatting
//////////////////////////////

`timescale 1ns/100ps

module core_top_tb
    import core_cfg_pkg::*;
    import core_io_pkg::*;
();

    localparam int RESET_HOLD        = 20;
    localparam int COIN_PULSE_CYCLES = 8;
    localparam int WAIT_LIMIT        = 200;

    logic         clk_74a;
    logic         reset;
    logic         bridge_reset;
    bridge_addr_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    cont_key_t    cont1_key;
    cont_key_t    cont2_key;
    cont_key_t    snac1_key;
    cont_key_t    snac2_key;
    cont_joy_t    snac1_joy;
    cont_joy_t    snac2_joy;
    rgb12_t       core_rgb;
    video_sync_t  core_sync;
    dip_word_t    dips;
    logic         core_reset;
    arcade_ctrl_t arcade_controls;
    rgb24_t       video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    int errors = 0;

    core_top #(
        .RESET_HOLD        (RESET_HOLD),
        .COIN_PULSE_CYCLES (COIN_PULSE_CYCLES)
    ) dut (.*);

    initial begin
        clk_74a = 1'b0;
        forever #5 clk_74a = ~clk_74a;
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////
    // inputs change 1 ns after the edge and outputs are read there too
    task automatic tick(input int n);
        repeat (n) @(posedge clk_74a);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        tick(1);
        bridge_wr      = 1'b0;
    endtask

    // read data is combinational and taken mid-cycle
    task automatic bridge_read(input bridge_addr_t addr, output bridge_data_t data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        #4;
        data        = bridge_rd_data;
        tick(1);
        bridge_rd   = 1'b0;
    endtask

    // core byte order with the original low byte on top
    function automatic logic [15:0] dip_model(input lives_t l, input difficulty_t d,
                                              input bonus_t b, input logic demo);
        return {2'b00, d, b, demo, 1'b0, l, 4'h0};
    endfunction

    // up, down, left, right, fire, start
    function automatic logic [5:0] pad_model(input cont_key_t k);
        return {k[0], k[1], k[2], k[3], k[4], k[15]};
    endfunction

    function automatic cont_key_t stick_model(input cont_key_t k, input cont_joy_t j);
        cont_key_t pad;
        pad    = k;
        pad[0] = (j[15:8] < stick_low);
        pad[1] = (j[15:8] > stick_high);
        pad[2] = (j[7:0] < stick_low);
        pad[3] = (j[7:0] > stick_high);
        return pad;
    endfunction

    // a nibble n widens to n times 11 hex
    function automatic rgb24_t rgb_model(input rgb12_t c);
        return {8'h11 * {4'h0, c[11:8]}, 8'h11 * {4'h0, c[7:4]}, 8'h11 * {4'h0, c[3:0]}};
    endfunction

    ////////////////////////////////
    // stimulus
    ////////////////////////////////
    initial begin
        bridge_data_t wdata;
        bridge_data_t rd;
        lives_t       l;
        difficulty_t  d;
        bonus_t       b;
        logic         demo;
        cont_key_t    key;
        cont_joy_t    joy;
        rgb12_t       pix;
        int           cnt;
        int           fails;

        void'($urandom(32'h2352d2f8));
        reset          = 1'b1;
        bridge_reset   = 1'b0;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        snac1_key      = '0;
        snac2_key      = '0;
        snac1_joy      = '0;
        snac2_joy      = '0;
        core_rgb       = '0;
        core_sync      = '0;
        tick(3);
        // state held in reset
        check_value("dips", dips, 32'h0);
        check_value("core_reset", core_reset, 1);
        check_value("coin", arcade_controls.coin, 0);
        check_value("video_de", video_de, 0);
        reset = 1'b0;
        tick(1);

        // settings into the dip word
        for (int i = 0; i < 8; i++) begin
            wdata = $urandom;
            l     = wdata[1:0];
            bridge_write(addr_lives, wdata);
            wdata = $urandom;
            d     = wdata[2:0];
            bridge_write(addr_difficulty, wdata);
            wdata = $urandom;
            b     = wdata[2:0];
            bridge_write(addr_bonus, wdata);
            demo  = i[0];
            bridge_write(addr_demo_sounds, {31'h0, demo});
            check_value("dips", dips, dip_model(l, d, b, demo));
        end

        // config read-back and zero at other addresses
        for (int i = 0; i < 6; i++) begin
            wdata = $urandom;
            bridge_write(addr_analogizer_cfg, wdata);
            bridge_read(addr_analogizer_cfg, rd);
            check_value("bridge_rd_data", rd, {20'h0, wdata[11:0]});
            bridge_read(bridge_addr_t'($urandom) >> 4, rd);
            check_value("bridge_rd_data", rd, 32'h0);
        end
        bridge_write(addr_analogizer_cfg, 32'h0);

        ////////////////////////////////
        // manual reset stretch
        ////////////////////////////////
        bridge_write(addr_reset, 32'h1);
        check_value("core_reset", core_reset, 0);
        tick(1);
        check_value("core_reset", core_reset, 1);
        // second toggle lands inside the stretch
        bridge_write(addr_reset, 32'h1);
        cnt = 2;
        while (core_reset && cnt <= WAIT_LIMIT) begin
            tick(1);
            if (core_reset) begin
                cnt++;
            end
        end
        if (cnt > WAIT_LIMIT) begin
            flag_error("timeout waiting for core_reset to fall");
        end
        check_value("core_reset cycles", cnt, RESET_HOLD);
        tick(4);
        check_value("core_reset", core_reset, 0);
        bridge_reset = 1'b1;
        tick(2);
        check_value("core_reset", core_reset, 1);
        bridge_reset = 1'b0;
        tick(1);
        check_value("core_reset", core_reset, 0);

        // pocket pads with the analogizer off
        for (int i = 0; i < 8; i++) begin
            key       = cont_key_t'($urandom) & 16'hBFFF;
            cont1_key = key;
            cont2_key = cont_key_t'($urandom);
            snac1_key = cont_key_t'($urandom);
            tick(2);
            check_value("arcade_controls", arcade_controls[6:1], pad_model(key));
        end

        // analog sticks with players swapped so SNAC2 drives p1
        bridge_write(addr_analogizer_ena, 32'h1);
        bridge_write(addr_analogizer_cfg, {20'h0, 1'b0, 4'h0, both_swapped, snac_analog_a});
        for (int i = 0; i < 16; i++) begin
            joy = $urandom;
            // threshold corners first
            if (i == 0) begin
                joy[15:0] = 16'h3FC1;
            end else if (i == 1) begin
                joy[15:0] = 16'h40C0;
            end
            key       = cont_key_t'($urandom) & 16'hBFFF;
            snac2_joy = joy;
            snac2_key = key;
            snac1_joy = $urandom;
            snac1_key = cont_key_t'($urandom);
            cont1_key = cont_key_t'($urandom) & 16'hBFFF;
            tick(2);
            check_value("arcade_controls", arcade_controls[6:1],
                        pad_model(stick_model(key, joy)));
        end
        bridge_write(addr_analogizer_ena, 32'h0);

        ////////////////////////////////
        // coin pulse on select release
        ////////////////////////////////
        cont1_key = 16'h4000;
        tick(3);
        cont1_key = 16'h0000;
        for (cnt = 1; cnt <= WAIT_LIMIT; cnt++) begin
            tick(1);
            if (arcade_controls.coin) begin
                break;
            end
        end
        if (cnt > WAIT_LIMIT) begin
            flag_error("timeout waiting for the coin pulse");
        end
        check_value("coin delay", cnt, 3);
        cnt = 1;
        while (arcade_controls.coin && cnt <= WAIT_LIMIT) begin
            // another press and release while counting must be ignored
            if (cnt == 1) begin
                cont1_key = 16'h4000;
            end else if (cnt == 3) begin
                cont1_key = 16'h0000;
            end
            tick(1);
            if (arcade_controls.coin) begin
                cnt++;
            end
        end
        if (cnt > WAIT_LIMIT) begin
            flag_error("timeout waiting for the coin pulse to end");
        end
        check_value("coin cycles", cnt, COIN_PULSE_CYCLES);

        // video with hs toggling every pixel and vs every fourth
        for (int i = 0; i < 8; i++) begin
            pix       = rgb12_t'($urandom);
            core_rgb  = pix;
            core_sync = {i[0], i[2], 2'b00};
            tick(1);
            check_value("video_rgb", video_rgb, rgb_model(pix));
            check_value("video_de", video_de, 1);
        end
        core_sync = 4'b0011;
        tick(2);
        check_value("video_de", video_de, 0);
        check_value("video_rgb", video_rgb, 32'h0);
        bridge_write(addr_analogizer_ena, 32'h1);
        bridge_write(addr_analogizer_cfg, 32'h800);
        core_sync = '0;
        core_rgb  = rgb12_t'($urandom) | 12'h001;
        tick(1);
        check_value("video_rgb", video_rgb, 32'h0);
        check_value("video_de", video_de, 1);

        tick(2);
        fails = dut.u_checker.fail_count;
        $display("errors: %0d check failures, %0d assertion failures", errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
